//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := ooo_backend_tb
FILELIST  := ooo_backend.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/branch_history.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module branch_history #(
    parameter int ENTRIES = `OOO_BHT_ENTRIES
) (
    input  wire                         clk_in,
    input  wire                         arst_n,
    input  wire [`OOO_XLEN-1:0]         lookup_pc,
    input  wire ooo_ctrl_pkg::bp_update_t update,
    output logic                        pred_taken
);

    import ooo_ctrl_pkg::*;

    localparam int IDX_W = $clog2(ENTRIES);

    logic [1:0]       counters [ENTRIES];
    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] update_idx;

    // word address bits, byte offset dropped
    assign lookup_idx = lookup_pc[IDX_W+1:2];
    assign update_idx = update.pc[IDX_W+1:2];

    // upper counter bit is the prediction
    assign pred_taken = counters[lookup_idx][1];

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            // weakly not-taken
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (update.valid) begin
            if (update.taken) begin
                if (counters[update_idx] != 2'b11) begin
                    counters[update_idx] <= counters[update_idx] + 2'b01;
                end
            end else begin
                if (counters[update_idx] != 2'b00) begin
                    counters[update_idx] <= counters[update_idx] - 2'b01;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/ooo_backend.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module ooo_backend (
    input  wire                           clk_in,
    input  wire                           arst_n,
    input  wire ooo_data_pkg::issue_req_t issue,
    input  wire ooo_data_pkg::complete_t  alu_done,
    input  wire ooo_data_pkg::complete_t  lsu_done,
    input  wire [`OOO_REG_IDX_W-1:0]      src1_reg,
    input  wire [`OOO_REG_IDX_W-1:0]      src2_reg,
    output logic                          issue_full,
    output logic [`OOO_ROB_IDX_W-1:0]     issue_tag,
    output logic                          pred_taken,
    output ooo_data_pkg::operand_t        operand1,
    output ooo_data_pkg::operand_t        operand2,
    output ooo_data_pkg::commit_t         commit,
    output ooo_ctrl_pkg::redirect_t       redirect
);

    import ooo_ctrl_pkg::*;
    import ooo_data_pkg::*;

    bp_update_t                bp_update;
    rob_read_t                 query1;
    rob_read_t                 query2;
    logic [`OOO_ROB_IDX_W-1:0] query1_tag;
    logic [`OOO_ROB_IDX_W-1:0] query2_tag;
    logic                      rename_valid;

    reorder_buffer u_rob (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .issue        (issue),
        .pred_taken   (pred_taken),
        .alu_done     (alu_done),
        .lsu_done     (lsu_done),
        .query1_tag   (query1_tag),
        .query2_tag   (query2_tag),
        .issue_full   (issue_full),
        .issue_tag    (issue_tag),
        .rename_valid (rename_valid),
        .query1       (query1),
        .query2       (query2),
        .commit       (commit),
        .bp_update    (bp_update),
        .redirect     (redirect)
    );

    // rename uses the tag handed out in the issue cycle
    reg_rename_file u_regs (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .rename_valid (rename_valid),
        .rename_rd    (issue.rd),
        .rename_tag   (issue_tag),
        .src1_reg     (src1_reg),
        .src2_reg     (src2_reg),
        .query1       (query1),
        .query2       (query2),
        .commit       (commit),
        .flush        (redirect.flush),
        .query1_tag   (query1_tag),
        .query2_tag   (query2_tag),
        .operand1     (operand1),
        .operand2     (operand2)
    );

    branch_history #(
        .ENTRIES (`OOO_BHT_ENTRIES)
    ) u_bht (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .lookup_pc  (issue.pc),
        .update     (bp_update),
        .pred_taken (pred_taken)
    );

endmodule

`default_nettype wire

//--- hdl/ooo_ctrl_pkg.sv
`default_nettype none

`include "ooo_defines.svh"

package ooo_ctrl_pkg;

    // instruction class kept per ROB entry
    typedef enum logic [2:0] {
        op_alu,
        op_load,
        op_store,
        op_branch,
        op_jump
    } op_class_e;

    // front end redirect after a wrong prediction
    typedef struct packed {
        logic                 flush;
        logic [`OOO_XLEN-1:0] target;
    } redirect_t;

    // training record for the branch predictor
    typedef struct packed {
        logic                 valid;
        logic [`OOO_XLEN-1:0] pc;
        logic                 taken;
    } bp_update_t;

endpackage

`default_nettype wire

//--- hdl/ooo_data_pkg.sv
`default_nettype none

`include "ooo_defines.svh"

package ooo_data_pkg;

    // decoded instruction entering the ROB
    typedef struct packed {
        logic                      valid;
        ooo_ctrl_pkg::op_class_e   op;
        logic [`OOO_REG_IDX_W-1:0] rd;
        logic [`OOO_XLEN-1:0]      pc;
    } issue_req_t;

    // result from an execution unit
    // lsu leaves taken and target at zero
    typedef struct packed {
        logic                      valid;
        logic [`OOO_ROB_IDX_W-1:0] tag;
        logic [`OOO_XLEN-1:0]      value;
        logic                      taken;
        logic [`OOO_XLEN-1:0]      target;
    } complete_t;

    // ROB answer to a forwarding query
    typedef struct packed {
        logic                 ready;
        logic [`OOO_XLEN-1:0] value;
    } rob_read_t;

    // operand lookup result
    typedef struct packed {
        logic                      ready;
        logic [`OOO_XLEN-1:0]      value;
        logic [`OOO_ROB_IDX_W-1:0] tag;
    } operand_t;

    // retired entry heading to the register file
    typedef struct packed {
        logic                      valid;
        logic [`OOO_REG_IDX_W-1:0] rd;
        logic [`OOO_ROB_IDX_W-1:0] tag;
        logic [`OOO_XLEN-1:0]      value;
        logic                      we;
    } commit_t;

endpackage

`default_nettype wire

//--- hdl/ooo_defines.svh
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// data path and address width
`define OOO_XLEN 32

// reorder buffer geometry
// depth must stay a power of two, tags wrap naturally
`define OOO_ROB_DEPTH 8
`define OOO_ROB_IDX_W 3

// architectural register file
`define OOO_NUM_REGS 32
`define OOO_REG_IDX_W 5

// default number of two-bit predictor counters
`define OOO_BHT_ENTRIES 64

`endif

//--- hdl/reg_rename_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module reg_rename_file (
    input  wire                          clk_in,
    input  wire                          arst_n,
    input  wire                          rename_valid,
    input  wire [`OOO_REG_IDX_W-1:0]     rename_rd,
    input  wire [`OOO_ROB_IDX_W-1:0]     rename_tag,
    input  wire [`OOO_REG_IDX_W-1:0]     src1_reg,
    input  wire [`OOO_REG_IDX_W-1:0]     src2_reg,
    input  wire ooo_data_pkg::rob_read_t query1,
    input  wire ooo_data_pkg::rob_read_t query2,
    input  wire ooo_data_pkg::commit_t   commit,
    input  wire                          flush,
    output logic [`OOO_ROB_IDX_W-1:0]    query1_tag,
    output logic [`OOO_ROB_IDX_W-1:0]    query2_tag,
    output ooo_data_pkg::operand_t       operand1,
    output ooo_data_pkg::operand_t       operand2
);

    import ooo_data_pkg::*;

    logic [`OOO_XLEN-1:0]      regs [`OOO_NUM_REGS];
    logic [`OOO_ROB_IDX_W-1:0] tags [`OOO_NUM_REGS];
    logic [`OOO_NUM_REGS-1:0]  busy;

    // busy registers take ROB state, free ones the stored value
    // x0 is never written nor busy so it always reads ready zero
    function automatic operand_t lookup(input logic [`OOO_REG_IDX_W-1:0] src,
                                        input rob_read_t fwd);
        operand_t res;
        res.tag = tags[src];
        if (busy[src]) begin
            res.ready = fwd.ready;
            res.value = fwd.value;
        end else begin
            res.ready = 1'b1;
            res.value = regs[src];
        end
        return res;
    endfunction

    assign query1_tag = tags[src1_reg];
    assign query2_tag = tags[src2_reg];
    assign operand1   = lookup(src1_reg, query1);
    assign operand2   = lookup(src2_reg, query2);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
            busy <= '0;
        end else begin
            // a jump commits its link value together with the flush
            if (commit.valid && commit.we && (commit.rd != '0)) begin
                regs[commit.rd] <= commit.value;
            end

            if (flush) begin
                busy <= '0;
                for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                    tags[i] <= '0;
                end
            end else begin
                // only the latest producer frees the register
                if (commit.valid && commit.we && busy[commit.rd] &&
                    (tags[commit.rd] == commit.tag)) begin
                    busy[commit.rd] <= 1'b0;
                end
                // rename comes last so it overrides the clear above
                if (rename_valid && (rename_rd != '0)) begin
                    busy[rename_rd] <= 1'b1;
                    tags[rename_rd] <= rename_tag;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module reorder_buffer (
    input  wire                              clk_in,
    input  wire                              arst_n,
    input  wire ooo_data_pkg::issue_req_t    issue,
    input  wire                              pred_taken,
    input  wire ooo_data_pkg::complete_t     alu_done,
    input  wire ooo_data_pkg::complete_t     lsu_done,
    input  wire [`OOO_ROB_IDX_W-1:0]         query1_tag,
    input  wire [`OOO_ROB_IDX_W-1:0]         query2_tag,
    output logic                             issue_full,
    output logic [`OOO_ROB_IDX_W-1:0]        issue_tag,
    output logic                             rename_valid,
    output ooo_data_pkg::rob_read_t          query1,
    output ooo_data_pkg::rob_read_t          query2,
    output ooo_data_pkg::commit_t            commit,
    output ooo_ctrl_pkg::bp_update_t         bp_update,
    output ooo_ctrl_pkg::redirect_t          redirect
);

    import ooo_ctrl_pkg::*;
    import ooo_data_pkg::*;

    localparam int CNT_W = `OOO_ROB_IDX_W + 1;

    typedef struct packed {
        logic                      ready;
        op_class_e                 op;
        logic [`OOO_REG_IDX_W-1:0] rd;
        logic [`OOO_XLEN-1:0]      pc;
        logic                      predicted;
        logic                      taken;
        logic [`OOO_XLEN-1:0]      target;
        logic [`OOO_XLEN-1:0]      value;
    } rob_entry_t;

    rob_entry_t                entries [`OOO_ROB_DEPTH];
    rob_entry_t                head_ent;
    logic [`OOO_ROB_IDX_W-1:0] head;
    logic [`OOO_ROB_IDX_W-1:0] tail;
    logic [CNT_W-1:0]          count;
    logic                      issue_accept;
    logic                      retire;
    logic                      alu_hit;
    logic                      lsu_hit;
    logic                      is_ctrl;
    logic                      eff_taken;
    logic                      mispredict;
    logic [`OOO_XLEN-1:0]      fix_pc;

    // tag lies between head and head+count
    function automatic logic in_flight(input logic [`OOO_ROB_IDX_W-1:0] tag,
                                       input logic [`OOO_ROB_IDX_W-1:0] hd,
                                       input logic [CNT_W-1:0] cnt);
        logic [`OOO_ROB_IDX_W-1:0] offset;
        offset = tag - hd;
        return ({1'b0, offset} < cnt);
    endfunction

    assign issue_full = (count == CNT_W'(`OOO_ROB_DEPTH));
    assign issue_tag  = tail;

    // nothing enters while the flush cycle is active
    assign issue_accept = issue.valid && !issue_full && !redirect.flush;
    assign rename_valid = issue_accept && (issue.op inside {op_alu, op_load, op_jump});

    // late completions of flushed tags are dropped
    assign alu_hit = alu_done.valid && !redirect.flush && in_flight(alu_done.tag, head, count);
    assign lsu_hit = lsu_done.valid && !redirect.flush && in_flight(lsu_done.tag, head, count);

    assign head_ent = entries[head];
    assign retire   = (count != '0) && head_ent.ready && !redirect.flush;

    // jumps always resolve taken
    assign is_ctrl    = (head_ent.op == op_branch) || (head_ent.op == op_jump);
    assign eff_taken  = head_ent.taken || (head_ent.op == op_jump);
    assign mispredict = is_ctrl && (head_ent.predicted != eff_taken);
    assign fix_pc     = eff_taken ? head_ent.target : head_ent.pc + `OOO_XLEN'(4);

    // forwarding reads for the rename file
    assign query1.ready = entries[query1_tag].ready;
    assign query1.value = entries[query1_tag].value;
    assign query2.ready = entries[query2_tag].ready;
    assign query2.value = entries[query2_tag].value;

    // entry storage
    always_ff @(posedge clk_in) begin
        if (issue_accept) begin
            entries[tail] <= '{
                ready:     1'b0,
                op:        issue.op,
                rd:        issue.rd,
                pc:        issue.pc,
                predicted: pred_taken,
                taken:     1'b0,
                target:    '0,
                value:     '0
            };
        end
        if (alu_hit) begin
            entries[alu_done.tag].ready  <= 1'b1;
            entries[alu_done.tag].value  <= alu_done.value;
            entries[alu_done.tag].taken  <= alu_done.taken;
            entries[alu_done.tag].target <= alu_done.target;
        end
        if (lsu_hit) begin
            entries[lsu_done.tag].ready  <= 1'b1;
            entries[lsu_done.tag].value  <= lsu_done.value;
            entries[lsu_done.tag].taken  <= lsu_done.taken;
            entries[lsu_done.tag].target <= lsu_done.target;
        end
    end

    // pointers, retire outputs and flush
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            commit    <= '0;
            bp_update <= '0;
            redirect  <= '0;
        end else if (redirect.flush) begin
            head            <= '0;
            tail            <= '0;
            count           <= '0;
            commit.valid    <= 1'b0;
            bp_update.valid <= 1'b0;
            redirect.flush  <= 1'b0;
        end else begin
            if (issue_accept) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(issue_accept) - CNT_W'(retire);

            commit.valid <= retire;
            commit.rd    <= head_ent.rd;
            commit.tag   <= head;
            commit.value <= head_ent.value;
            commit.we    <= head_ent.op inside {op_alu, op_load, op_jump};

            bp_update.valid <= retire && (head_ent.op == op_branch);
            bp_update.pc    <= head_ent.pc;
            bp_update.taken <= head_ent.taken;

            redirect.flush  <= retire && mispredict;
            redirect.target <= fix_pc;
        end
    end

endmodule

`default_nettype wire

//--- ooo_backend.f
+incdir+hdl
hdl/ooo_ctrl_pkg.sv
hdl/ooo_data_pkg.sv
hdl/branch_history.sv
hdl/reorder_buffer.sv
hdl/reg_rename_file.sv
hdl/ooo_backend.sv
testbench/ooo_backend_assert.sv
testbench/ooo_backend_tb.sv

//--- testbench/ooo_backend_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module rob_checks (
    input  wire                          clk_in,
    input  wire                          arst_n,
    input  wire                          issue_full,
    input  wire [`OOO_ROB_IDX_W-1:0]     tail,
    input  wire                          head_ready,
    input  wire [`OOO_ROB_IDX_W:0]       count,
    input  wire ooo_data_pkg::commit_t   commit,
    input  wire ooo_ctrl_pkg::redirect_t redirect
);

    // the flush cycle blocks the retire path
    flush_quiet: assert property (
        @(posedge clk_in) disable iff (!arst_n)
        redirect.flush |=> !commit.valid && !redirect.flush
    ) else $error("commit or redirect active in the cycle after a flush");

    // a held issue leaves the tail where it is
    no_issue_when_full: assert property (
        @(posedge clk_in) disable iff (!arst_n)
        issue_full && !redirect.flush |=> $stable(tail)
    ) else $error("issue accepted while the ROB was full");

    // commit is registered, so look one cycle back at the head
    commit_from_ready_head: assert property (
        @(posedge clk_in) disable iff (!arst_n)
        commit.valid |-> $past(head_ready && (count != '0))
    ) else $error("commit without a ready head entry");

endmodule

bind reorder_buffer rob_checks u_rob_checks (
    .clk_in       (clk_in),
    .arst_n       (arst_n),
    .issue_full   (issue_full),
    .tail         (tail),
    .head_ready   (head_ent.ready),
    .count        (count),
    .commit       (commit),
    .redirect     (redirect)
);

`default_nettype wire

//--- testbench/ooo_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module ooo_backend_tb;

    import ooo_ctrl_pkg::*;
    import ooo_data_pkg::*;

    // generous cap over the few hundred cycles the tests take
    localparam int MAX_CYCLES = 3000;
    localparam int BHT_W      = $clog2(`OOO_BHT_ENTRIES);

    // what the model keeps for each ROB tag
    typedef struct packed {
        op_class_e                 op;
        logic [`OOO_REG_IDX_W-1:0] rd;
        logic [`OOO_XLEN-1:0]      pc;
        logic                      pred;
        logic                      taken;
        logic [`OOO_XLEN-1:0]      target;
        logic [`OOO_XLEN-1:0]      value;
    } model_entry_t;

    logic                      clk_in;
    logic                      arst_n;
    issue_req_t                issue;
    complete_t                 alu_done;
    complete_t                 lsu_done;
    logic [`OOO_REG_IDX_W-1:0] src1_reg;
    logic [`OOO_REG_IDX_W-1:0] src2_reg;
    logic                      issue_full;
    logic [`OOO_ROB_IDX_W-1:0] issue_tag;
    logic                      pred_taken;
    operand_t                  operand1;
    operand_t                  operand2;
    commit_t                   commit;
    redirect_t                 redirect;

    model_entry_t              model_rob [`OOO_ROB_DEPTH];
    logic [`OOO_ROB_IDX_W-1:0] pending [$];
    logic [`OOO_ROB_IDX_W-1:0] model_tail;
    logic [`OOO_XLEN-1:0]      model_regs [`OOO_NUM_REGS];
    logic [1:0]                model_ctr [`OOO_BHT_ENTRIES];
    logic [31:0]               lfsr;
    int                        cycles;
    int                        errors;
    int                        checks;

    ooo_backend dut (.*);

    initial clk_in = 1'b0;
    always #10 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] res;
        res = '0;
        for (int i = 0; i < n; i++) begin
            res  = {res[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return res;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic report_test(input string name, input int start_err);
        $display("%-16s done, %0d errors", name, errors - start_err);
    endtask

    // advance one clock and compare any retirement with the model
    task automatic tick();
        model_entry_t              ent;
        logic [`OOO_ROB_IDX_W-1:0] tag;
        logic [BHT_W-1:0]          idx;
        logic                      eff_taken;
        logic                      exp_flush;
        logic                      exp_we;
        @(posedge clk_in);
        @(negedge clk_in);
        alu_done.valid = 1'b0;
        lsu_done.valid = 1'b0;
        if (commit.valid) begin
            checks++;
            if (pending.size() == 0) begin
                flag_error("commit while no entry was in flight");
            end else begin
                tag       = pending.pop_front();
                ent       = model_rob[tag];
                exp_we    = ent.op inside {op_alu, op_load, op_jump};
                eff_taken = ent.taken || (ent.op == op_jump);
                exp_flush = (ent.op inside {op_branch, op_jump}) && (ent.pred != eff_taken);
                if (commit.tag != tag || commit.rd != ent.rd || commit.we != exp_we ||
                    commit.value != ent.value) begin
                    flag_error($sformatf(
                        "commit tag %0d rd %0d we %0b value %h, expected %0d %0d %0b %h",
                        commit.tag, commit.rd, commit.we, commit.value,
                        tag, ent.rd, exp_we, ent.value));
                end
                if (exp_we && ent.rd != '0) model_regs[ent.rd] = ent.value;
                if (ent.op == op_branch) begin
                    idx = ent.pc[BHT_W+1:2];
                    if (ent.taken && model_ctr[idx] != 2'b11) begin
                        model_ctr[idx] = model_ctr[idx] + 2'b01;
                    end else if (!ent.taken && model_ctr[idx] != 2'b00) begin
                        model_ctr[idx] = model_ctr[idx] - 2'b01;
                    end
                end
                if (redirect.flush != exp_flush) begin
                    flag_error($sformatf("redirect flush %0b, expected %0b",
                                         redirect.flush, exp_flush));
                end else if (exp_flush &&
                             redirect.target != (eff_taken ? ent.target : ent.pc + 32'd4)) begin
                    flag_error($sformatf("redirect target %h is wrong", redirect.target));
                end
                // younger entries are gone with the flush
                if (exp_flush) begin
                    pending.delete();
                    model_tail = '0;
                end
            end
        end else if (redirect.flush) begin
            flag_error("redirect raised without a commit");
        end
    endtask

    task automatic issue_op(input op_class_e op, input logic [4:0] rd, input logic [31:0] pc);
        int waited;
        waited = 0;
        issue  = '{valid: 1'b1, op: op, rd: rd, pc: pc};
        #1;
        while (issue_full && waited < 20) begin
            tick();
            waited++;
        end
        if (issue_full) begin
            flag_error("issue stayed blocked for 20 cycles with the ROB full");
            issue.valid = 1'b0;
            return;
        end
        checks++;
        if (issue_tag != model_tail || pred_taken != model_ctr[pc[BHT_W+1:2]][1]) begin
            flag_error($sformatf("issue tag %0d pred %0b, expected %0d %0b", issue_tag,
                pred_taken, model_tail, model_ctr[pc[BHT_W+1:2]][1]));
        end
        model_rob[model_tail] = '{op: op, rd: rd, pc: pc, pred: model_ctr[pc[BHT_W+1:2]][1],
                                  taken: 1'b0, target: '0, value: '0};
        pending.push_back(model_tail);
        model_tail = model_tail + 1'b1;
        tick();
        issue.valid = 1'b0;
    endtask

    task automatic drive_done(input logic [2:0] tag, input logic [31:0] value,
                              input logic taken, input logic [31:0] target, input logic lsu);
        complete_t c;
        c = '{valid: 1'b1, tag: tag, value: value, taken: taken, target: target};
        model_rob[tag].value  = value;
        model_rob[tag].taken  = taken;
        model_rob[tag].target = target;
        if (lsu) lsu_done = c;
        else alu_done = c;
    endtask

    task automatic complete(input logic [2:0] tag, input logic [31:0] value,
                            input logic taken, input logic [31:0] target, input logic lsu);
        drive_done(tag, value, taken, target, lsu);
        tick();
    endtask

    // wait until at most `left` entries are in flight plus one writeback cycle
    task automatic wait_drain(input int left);
        int n;
        n = 0;
        while (pending.size() > left && n < 40) begin
            tick();
            n++;
        end
        if (pending.size() > left) flag_error("entries did not retire within 40 cycles");
        tick();
    endtask

    // both lookup ports read the same register
    task automatic check_operand(input logic [4:0] r, input logic ready,
                                 input logic [31:0] value, input logic [2:0] tag);
        operand_t ops [2];
        src1_reg = r;
        src2_reg = r;
        #1;
        ops[0] = operand1;
        ops[1] = operand2;
        foreach (ops[p]) begin
            checks++;
            if (ops[p].ready != ready || (ready && ops[p].value != value) ||
                (!ready && ops[p].tag != tag)) begin
                flag_error($sformatf("x%0d port %0d reads ready %0b value %h tag %0d", r,
                    p + 1, ops[p].ready, ops[p].value, ops[p].tag));
            end
        end
    endtask

    task automatic in_order_retire();
        logic [2:0] order [6];
        logic [2:0] first;
        logic [2:0] swap;
        int         j;
        int         start_err;
        start_err = errors;
        first     = model_tail;
        for (int i = 0; i < 6; i++) begin
            issue_op(op_alu, 5'(i + 1), 32'h1000 + 32'(4 * i));
            order[i] = first + 3'(i);
        end
        // shuffled completion order
        for (int i = 5; i > 0; i--) begin
            j        = int'(rand_bits(3)) % (i + 1);
            swap     = order[i];
            order[i] = order[j];
            order[j] = swap;
        end
        foreach (order[i]) begin
            complete(order[i], rand_bits(32), 1'b0, '0, 1'b0);
        end
        wait_drain(0);
        for (int i = 1; i <= 6; i++) begin
            check_operand(5'(i), 1'b1, model_regs[i], '0);
        end
        report_test("in-order retire", start_err);
    endtask

    task automatic full_backpressure();
        logic [2:0] first;
        int         start_err;
        start_err = errors;
        first     = model_tail;
        for (int i = 0; i < 8; i++) begin
            issue_op(op_alu, 5'(10 + i), 32'h2000 + 32'(4 * i));
        end
        checks++;
        if (!issue_full) flag_error("issue_full low with eight entries in flight");
        // ninth issue held while the oldest entry completes
        issue = '{valid: 1'b1, op: op_alu, rd: 5'd18, pc: 32'h2020};
        drive_done(first, rand_bits(32), 1'b0, '0, 1'b0);
        tick();
        checks++;
        if (!issue_full) flag_error("ninth issue accepted while the ROB was full");
        issue_op(op_alu, 5'd18, 32'h2020);
        for (int i = 1; i <= 8; i++) begin
            complete(first + 3'(i), rand_bits(32), 1'b0, '0, 1'b0);
        end
        wait_drain(0);
        check_operand(5'd18, 1'b1, model_regs[18], '0);
        report_test("full", start_err);
    endtask

    task automatic operand_forwarding();
        logic [2:0] t0;
        int         start_err;
        start_err = errors;
        t0        = model_tail;
        issue_op(op_alu, 5'd6, 32'h3000);
        issue_op(op_alu, 5'd5, 32'h3004);
        issue_op(op_alu, 5'd5, 32'h3008);
        issue_op(op_alu, 5'd0, 32'h300c);
        check_operand(5'd0, 1'b1, '0, '0);
        check_operand(5'd5, 1'b0, '0, t0 + 3'd2);
        complete(t0 + 3'd1, rand_bits(32), 1'b0, '0, 1'b0);
        check_operand(5'd5, 1'b0, '0, t0 + 3'd2);
        complete(t0, rand_bits(32), 1'b0, '0, 1'b0);
        wait_drain(2);
        // older producer retired, younger tag still owns x5
        check_operand(5'd5, 1'b0, '0, t0 + 3'd2);
        complete(t0 + 3'd2, rand_bits(32), 1'b0, '0, 1'b0);
        check_operand(5'd5, 1'b1, model_rob[t0 + 3'd2].value, '0);
        complete(t0 + 3'd3, rand_bits(32), 1'b0, '0, 1'b0);
        wait_drain(0);
        check_operand(5'd5, 1'b1, model_regs[5], '0);
        check_operand(5'd0, 1'b1, '0, '0);
        report_test("forwarding", start_err);
    endtask

    task automatic mispredict_flush();
        logic [2:0] first;
        int         start_err;
        start_err = errors;
        first     = model_tail;
        issue_op(op_branch, 5'd0, 32'h0000_0100);
        issue_op(op_alu, 5'd7, 32'h0000_0104);
        issue_op(op_alu, 5'd8, 32'h0000_0108);
        complete(first + 3'd2, rand_bits(32), 1'b0, '0, 1'b0);
        complete(first + 3'd1, rand_bits(32), 1'b0, '0, 1'b0);
        complete(first, '0, 1'b1, 32'h0000_0200, 1'b0);
        wait_drain(0);
        checks++;
        if (issue_tag != '0 || issue_full) flag_error("ROB not empty after the flush");
        check_operand(5'd7, 1'b1, model_regs[7], '0);
        check_operand(5'd8, 1'b1, model_regs[8], '0);
        // same branch now predicted taken, resolves not taken
        first = model_tail;
        issue_op(op_branch, 5'd0, 32'h0000_0100);
        issue_op(op_alu, 5'd7, 32'h0000_0104);
        complete(first, '0, 1'b0, '0, 1'b0);
        wait_drain(0);
        check_operand(5'd7, 1'b1, model_regs[7], '0);
        report_test("mispredict", start_err);
    endtask

    task automatic predictor_training();
        logic [2:0] first;
        int         start_err;
        start_err = errors;
        issue.pc  = 32'h0000_0334;
        #1;
        checks++;
        if (pred_taken) flag_error("untrained branch predicted taken");
        for (int i = 0; i < 2; i++) begin
            first = model_tail;
            issue_op(op_branch, 5'd0, 32'h0000_0334);
            complete(first, '0, 1'b1, 32'h0000_0400, 1'b0);
            wait_drain(0);
        end
        issue.pc = 32'h0000_0334;
        #1;
        checks++;
        if (!pred_taken) flag_error("branch still predicted not taken after two taken");
        report_test("training", start_err);
    endtask

    task automatic store_commit();
        logic [2:0] first;
        int         start_err;
        start_err = errors;
        first     = model_tail;
        issue_op(op_alu, 5'd9, 32'h0000_0500);
        issue_op(op_store, 5'd9, 32'h0000_0504);
        complete(first, rand_bits(32), 1'b0, '0, 1'b0);
        complete(first + 3'd1, rand_bits(32), 1'b0, '0, 1'b1);
        wait_drain(0);
        check_operand(5'd9, 1'b1, model_regs[9], '0);
        report_test("store", start_err);
    endtask

    initial begin
        lfsr       = 32'h643e;
        issue      = '0;
        alu_done   = '0;
        lsu_done   = '0;
        src1_reg   = '0;
        src2_reg   = '0;
        model_tail = '0;
        errors     = 0;
        checks     = 0;
        foreach (model_regs[i]) model_regs[i] = '0;
        foreach (model_ctr[i]) model_ctr[i] = 2'b01;
        arst_n = 1'b0;
        repeat (10) @(negedge clk_in);
        arst_n = 1'b1;
        in_order_retire();
        full_backpressure();
        operand_forwarding();
        mispredict_flush();
        predictor_training();
        store_commit();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
